//--- design/sq_params.svh
`ifndef SQ_PARAMS_SVH
`define SQ_PARAMS_SVH

// Queue geometry, depth must stay a power of two
`define SQ_DEPTH       8
`define SQ_INDEX_W     3
`define SQ_COUNT_W     4

// Address and data widths
`define SQ_ADDR_W      32
`define SQ_OFFSET_W    3
`define SQ_WORD_ADDR_W 29
`define SQ_DATA_W      64

`endif

//--- design/sq_pkg.sv
`include "sq_params.svh"

package sq_pkg;

  // Word address in the upper bits, byte offset in the lower bits
  typedef struct packed {
    logic [`SQ_WORD_ADDR_W-1:0] word_addr;
    logic [`SQ_OFFSET_W-1:0]    offset;
  } store_address_split_t;

  // One address word, read raw or split
  typedef union packed {
    logic [`SQ_ADDR_W-1:0] raw;
    store_address_split_t  split;
  } store_address_t;

endpackage

//--- design/sq_pointers.sv
`timescale 1ns/1ps
`include "sq_params.svh"

module sq_pointers (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   dispatch_store,
  input  logic                   retire_store,
  input  logic                   rollback,
  input  logic [`SQ_INDEX_W-1:0] rollback_tail,
  input  logic                   drain_done,
  output logic [`SQ_INDEX_W-1:0] head,
  output logic [`SQ_INDEX_W-1:0] tail,
  output logic                   dispatch_ready,
  output logic                   dispatch_allocate,
  output logic                   drain_pending
);

  // Extra wrap bit on each pointer tells full from empty
  logic [`SQ_COUNT_W-1:0] head_ptr;
  logic [`SQ_COUNT_W-1:0] commit_ptr;
  logic [`SQ_COUNT_W-1:0] tail_ptr;
  logic [`SQ_COUNT_W-1:0] count;
  logic [`SQ_INDEX_W-1:0] cut;

  assign head  = head_ptr[`SQ_INDEX_W-1:0];
  assign tail  = tail_ptr[`SQ_INDEX_W-1:0];
  assign count = tail_ptr - head_ptr;

  // Entries removed by a rollback
  assign cut = tail - rollback_tail;

  assign dispatch_ready    = count < `SQ_COUNT_W'(`SQ_DEPTH);
  assign dispatch_allocate = dispatch_store && dispatch_ready && !rollback;

  // Retired stores not yet written out
  assign drain_pending = commit_ptr != head_ptr;

  always_ff @(posedge clock) begin
    if (reset) begin
      head_ptr   <= '0;
      commit_ptr <= '0;
      tail_ptr   <= '0;
    end else begin
      if (drain_done) begin
        head_ptr <= head_ptr + 1'b1;
      end
      if (retire_store) begin
        commit_ptr <= commit_ptr + 1'b1;
      end
      // Rollback wins over dispatch
      if (rollback) begin
        tail_ptr <= tail_ptr - {1'b0, cut};
      end else if (dispatch_allocate) begin
        tail_ptr <= tail_ptr + 1'b1;
      end
    end
  end

endmodule

//--- design/sq_drain_fsm.sv
`timescale 1ns/1ps

module sq_drain_fsm (
  input  logic clock,
  input  logic reset,
  input  logic drain_pending,
  input  logic wb_ack,
  output logic wb_cyc,
  output logic wb_stb,
  output logic wb_we,
  output logic drain_done
);

  localparam logic STATE_IDLE  = 1'b0;
  localparam logic STATE_WRITE = 1'b1;

  logic state;
  logic next_state;

  always_comb begin
    next_state = state;
    case (state)
      STATE_IDLE: begin
        if (drain_pending) begin
          next_state = STATE_WRITE;
        end
      end
      STATE_WRITE: begin
        // Back to idle for one cycle after every ack
        if (wb_ack) begin
          next_state = STATE_IDLE;
        end
      end
      default: next_state = STATE_IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= STATE_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Classic cycle, strobes held until ack
  assign wb_cyc     = state == STATE_WRITE;
  assign wb_stb     = state == STATE_WRITE;
  assign wb_we      = state == STATE_WRITE;
  assign drain_done = (state == STATE_WRITE) && wb_ack;

endmodule

//--- design/sq_entries.sv
`timescale 1ns/1ps
`include "sq_params.svh"

module sq_entries
  import sq_pkg::*;
(
  input  logic                                         clock,
  input  logic                                         reset,
  input  logic                                         dispatch_allocate,
  input  logic [`SQ_INDEX_W-1:0]                       tail,
  input  logic                                         execute_valid,
  input  logic [`SQ_INDEX_W-1:0]                       execute_index,
  input  store_address_t                               execute_address,
  input  logic [`SQ_DATA_W-1:0]                        execute_data,
  input  logic [`SQ_INDEX_W-1:0]                       head,
  output logic [`SQ_DEPTH-1:0][`SQ_WORD_ADDR_W-1:0]    entry_word_addr,
  output logic [`SQ_DEPTH-1:0][`SQ_DATA_W-1:0]         entry_data,
  output logic [`SQ_DEPTH-1:0]                         entry_executed,
  output logic [`SQ_WORD_ADDR_W-1:0]                   wb_adr,
  output logic [`SQ_DATA_W-1:0]                        wb_dat_w
);

  // Executed flags
  always_ff @(posedge clock) begin
    if (reset) begin
      entry_executed <= '0;
    end else begin
      if (dispatch_allocate) begin
        entry_executed[tail] <= 1'b0;
      end
      if (execute_valid) begin
        entry_executed[execute_index] <= 1'b1;
      end
    end
  end

  // Address and data payload
  always_ff @(posedge clock) begin
    if (execute_valid) begin
      entry_word_addr[execute_index] <= execute_address.split.word_addr;
      entry_data[execute_index]      <= execute_data;
    end
  end

  // Oldest committed store goes out on the bus
  assign wb_adr   = entry_word_addr[head];
  assign wb_dat_w = entry_data[head];

endmodule

//--- design/sq_forward.sv
`timescale 1ns/1ps
`include "sq_params.svh"

module sq_forward
  import sq_pkg::*;
(
  input  store_address_t                               load_address,
  input  logic [`SQ_INDEX_W-1:0]                       load_store_index,
  input  logic [`SQ_INDEX_W-1:0]                       head,
  input  logic [`SQ_DEPTH-1:0][`SQ_WORD_ADDR_W-1:0]    entry_word_addr,
  input  logic [`SQ_DEPTH-1:0][`SQ_DATA_W-1:0]         entry_data,
  input  logic [`SQ_DEPTH-1:0]                         entry_executed,
  output logic                                         load_hit,
  output logic [`SQ_DATA_W-1:0]                        load_data
);

  // Stores between head and the load's position
  logic [`SQ_INDEX_W-1:0] older_count;

  assign older_count = load_store_index - head;

  // Oldest first so the youngest match is written last
  always_comb begin : search
    logic [`SQ_INDEX_W-1:0] position;
    load_hit  = 1'b0;
    load_data = '0;
    for (int j = `SQ_DEPTH - 1; j >= 0; j--) begin
      position = load_store_index - `SQ_INDEX_W'(j + 1);
      if (`SQ_INDEX_W'(j) < older_count && entry_executed[position] &&
          entry_word_addr[position] == load_address.split.word_addr) begin
        load_hit  = 1'b1;
        load_data = entry_data[position];
      end
    end
  end

endmodule

//--- design/store_queue.sv
`timescale 1ns/1ps
`include "sq_params.svh"

module store_queue
  import sq_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       dispatch_store,
  output logic                       dispatch_ready,
  output logic [`SQ_INDEX_W-1:0]     dispatch_index,
  input  logic                       execute_valid,
  input  logic [`SQ_INDEX_W-1:0]     execute_index,
  input  logic [`SQ_ADDR_W-1:0]      execute_address,
  input  logic [`SQ_DATA_W-1:0]      execute_data,
  input  logic                       retire_store,
  input  logic                       rollback,
  input  logic [`SQ_INDEX_W-1:0]     rollback_tail,
  input  logic [`SQ_ADDR_W-1:0]      load_address,
  input  logic [`SQ_INDEX_W-1:0]     load_store_index,
  output logic                       load_hit,
  output logic [`SQ_DATA_W-1:0]      load_data,
  output logic                       wb_cyc,
  output logic                       wb_stb,
  output logic                       wb_we,
  output logic [`SQ_WORD_ADDR_W-1:0] wb_adr,
  output logic [`SQ_DATA_W-1:0]      wb_dat_w,
  input  logic                       wb_ack
);

  logic [`SQ_INDEX_W-1:0]                      head;
  logic                                        dispatch_allocate;
  logic                                        drain_pending;
  logic                                        drain_done;
  logic [`SQ_DEPTH-1:0][`SQ_WORD_ADDR_W-1:0]   entry_word_addr;
  logic [`SQ_DEPTH-1:0][`SQ_DATA_W-1:0]        entry_data;
  logic [`SQ_DEPTH-1:0]                        entry_executed;
  store_address_t                              execute_store_address;
  store_address_t                              load_store_address;

  assign execute_store_address.raw = execute_address;
  assign load_store_address.raw    = load_address;

  // Tail doubles as the index handed to dispatch
  sq_pointers i_pointers (
    .clock             (clock),
    .reset             (reset),
    .dispatch_store    (dispatch_store),
    .retire_store      (retire_store),
    .rollback          (rollback),
    .rollback_tail     (rollback_tail),
    .drain_done        (drain_done),
    .head              (head),
    .tail              (dispatch_index),
    .dispatch_ready    (dispatch_ready),
    .dispatch_allocate (dispatch_allocate),
    .drain_pending     (drain_pending)
  );

  sq_drain_fsm i_drain_fsm (
    .clock         (clock),
    .reset         (reset),
    .drain_pending (drain_pending),
    .wb_ack        (wb_ack),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .drain_done    (drain_done)
  );

  sq_entries i_entries (
    .clock             (clock),
    .reset             (reset),
    .dispatch_allocate (dispatch_allocate),
    .tail              (dispatch_index),
    .execute_valid     (execute_valid),
    .execute_index     (execute_index),
    .execute_address   (execute_store_address),
    .execute_data      (execute_data),
    .head              (head),
    .entry_word_addr   (entry_word_addr),
    .entry_data        (entry_data),
    .entry_executed    (entry_executed),
    .wb_adr            (wb_adr),
    .wb_dat_w          (wb_dat_w)
  );

  sq_forward i_forward (
    .load_address     (load_store_address),
    .load_store_index (load_store_index),
    .head             (head),
    .entry_word_addr  (entry_word_addr),
    .entry_data       (entry_data),
    .entry_executed   (entry_executed),
    .load_hit         (load_hit),
    .load_data        (load_data)
  );

endmodule

//--- bench/sq_clock_gen.sv
`timescale 1ns/1ps

module sq_clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  initial begin
    reset = 1'b1;
    repeat (4) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

//--- bench/sq_asserts.sv
`timescale 1ns/1ps
`include "sq_params.svh"

module sq_asserts (
  input logic                       clock,
  input logic                       reset,
  input logic                       dispatch_ready,
  input logic                       load_hit,
  input logic                       wb_cyc,
  input logic                       wb_stb,
  input logic [`SQ_WORD_ADDR_W-1:0] wb_adr,
  input logic [`SQ_DATA_W-1:0]      wb_dat_w,
  input logic                       wb_ack
);

  int failures = 0;

  // Idle outputs straight out of reset
  reset_state : assert property (@(posedge clock)
    $fell(reset) |-> !wb_cyc && !wb_stb && !load_hit && dispatch_ready)
    else begin
      $error("outputs not idle after reset");
      failures++;
    end

  cyc_equals_stb : assert property (@(posedge clock) disable iff (reset)
    wb_cyc == wb_stb)
    else begin
      $error("wb_cyc and wb_stb differ");
      failures++;
    end

  // Classic cycle holds until ack
  hold_until_ack : assert property (@(posedge clock) disable iff (reset)
    wb_cyc && !wb_ack |=> wb_cyc && $stable(wb_adr) && $stable(wb_dat_w))
    else begin
      $error("Wishbone write changed before ack");
      failures++;
    end

endmodule

bind store_queue sq_asserts i_asserts (.*);

//--- bench/sq_tb.sv
`timescale 1ns/1ps
`include "sq_params.svh"

module sq_tb;

  localparam int ROUNDS  = 6;
  localparam int NUM_OPS = 48 + ROUNDS * 16;

  logic clock, reset;
  logic dispatch_store, dispatch_ready, execute_valid, retire_store, rollback;
  logic [`SQ_INDEX_W-1:0] dispatch_index, execute_index, rollback_tail, load_store_index;
  logic [`SQ_ADDR_W-1:0] execute_address, load_address;
  logic [`SQ_DATA_W-1:0] execute_data, load_data, wb_dat_w;
  logic load_hit, wb_cyc, wb_stb, wb_we;
  logic wb_ack = 1'b0;
  logic [`SQ_WORD_ADDR_W-1:0] wb_adr;

  // Reference model
  logic [`SQ_WORD_ADDR_W-1:0] word_m [`SQ_DEPTH];
  logic [`SQ_DATA_W-1:0]      data_m [`SQ_DEPTH];
  logic                       exec_m [`SQ_DEPTH];
  logic [`SQ_INDEX_W-1:0]     head_m, commit_m, tail_m;
  logic [`SQ_WORD_ADDR_W+`SQ_DATA_W-1:0] expected_writes [$];
  logic [15:0] stim_lfsr, slave_lfsr;
  logic [1:0]  ack_wait;
  int errors, checks, acks;

  sq_clock_gen i_clock_gen (.clock(clock), .reset(reset));

  store_queue i_dut (.*);

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(inout logic [15:0] state, input int n,
                           output logic [63:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_step(state);
      value = {value[62:0], state[0]};
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error: %s = %h, expected %h", name, got, exp);
    end
  endtask

  task automatic dispatch_one();
    @(negedge clock);
    while (!dispatch_ready) @(negedge clock);
    check_value("dispatch_index", dispatch_index, tail_m);
    @(posedge clock);
    dispatch_store <= 1'b1;
    @(posedge clock);
    dispatch_store <= 1'b0;
    exec_m[tail_m] = 1'b0;
    tail_m++;
  endtask

  task automatic execute_one(input logic [`SQ_INDEX_W-1:0] index);
    logic [63:0] r;
    logic [`SQ_ADDR_W-1:0] addr;
    take_bits(stim_lfsr, 5, r);
    // Few distinct words so loads match several stores
    addr = {`SQ_WORD_ADDR_W'(29'h100 + r[4:3]), r[2:0]};
    take_bits(stim_lfsr, 64, r);
    @(posedge clock);
    execute_valid   <= 1'b1;
    execute_index   <= index;
    execute_address <= addr;
    execute_data    <= r;
    @(posedge clock);
    execute_valid <= 1'b0;
    word_m[index] = addr[`SQ_ADDR_W-1:`SQ_OFFSET_W];
    data_m[index] = r;
    exec_m[index] = 1'b1;
  endtask

  task automatic retire_one();
    expected_writes.push_back({word_m[commit_m], data_m[commit_m]});
    @(posedge clock);
    retire_store <= 1'b1;
    @(posedge clock);
    retire_store <= 1'b0;
    commit_m++;
  endtask

  task automatic rollback_to(input logic [`SQ_INDEX_W-1:0] t);
    @(posedge clock);
    rollback      <= 1'b1;
    rollback_tail <= t;
    @(posedge clock);
    rollback <= 1'b0;
    tail_m = t;
    @(negedge clock);
    check_value("dispatch_index", dispatch_index, t);
  endtask

  task automatic wait_drained();
    @(posedge clock);
    while (head_m != commit_m) @(posedge clock);
  endtask

  // Youngest older executed store with the same word wins
  task automatic check_load(input logic [`SQ_INDEX_W-1:0] lsi);
    logic [63:0] r;
    logic [`SQ_ADDR_W-1:0] addr;
    logic [`SQ_INDEX_W-1:0] n, p;
    logic hit;
    logic [`SQ_DATA_W-1:0] data;
    take_bits(stim_lfsr, 5, r);
    addr = {`SQ_WORD_ADDR_W'(29'h100 + r[4:3]), r[2:0]};
    @(posedge clock);
    load_address     <= addr;
    load_store_index <= lsi;
    @(negedge clock);
    hit  = 1'b0;
    data = '0;
    n = lsi - head_m;
    for (int j = 0; j < n; j++) begin
      p = lsi - `SQ_INDEX_W'(j + 1);
      if (!hit && exec_m[p] && word_m[p] == addr[`SQ_ADDR_W-1:`SQ_OFFSET_W]) begin
        hit  = 1'b1;
        data = data_m[p];
      end
    end
    check_value("load_hit", load_hit, hit);
    if (hit) check_value("load_data", load_data, data);
  endtask

  // Wishbone slave with 0 to 3 wait cycles
  always @(posedge clock) begin
    logic [63:0] r;
    if (reset) begin
      wb_ack   <= 1'b0;
      ack_wait <= 2'd1;
    end else if (wb_ack) begin
      wb_ack <= 1'b0;
      take_bits(slave_lfsr, 2, r);
      ack_wait <= r[1:0];
    end else if (wb_cyc) begin
      if (ack_wait == 0) wb_ack <= 1'b1;
      else ack_wait <= ack_wait - 1'b1;
    end
  end

  // Writes taken at ack against retire order
  always @(negedge clock) begin
    if (!reset && wb_cyc && wb_ack) begin
      check_value("wb_we", wb_we, 1'b1);
      if (expected_writes.size() == 0) begin
        errors++;
        $display("Wishbone write seen with no retired store waiting");
      end else begin
        check_value("wb_adr", wb_adr, expected_writes[0][`SQ_DATA_W +: `SQ_WORD_ADDR_W]);
        check_value("wb_dat_w", wb_dat_w, expected_writes[0][`SQ_DATA_W-1:0]);
        void'(expected_writes.pop_front());
      end
      head_m++;
      acks++;
    end
  end

  initial begin
    repeat (NUM_OPS * 10 + 200) @(posedge clock);
    $display("Timeout: the run did not finish in time");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [63:0] r;
    dispatch_store   = 1'b0;
    execute_valid    = 1'b0;
    execute_index    = '0;
    execute_address  = '0;
    execute_data     = '0;
    retire_store     = 1'b0;
    rollback         = 1'b0;
    rollback_tail    = '0;
    load_address     = '0;
    load_store_index = '0;
    head_m = '0;
    commit_m = '0;
    tail_m = '0;
    stim_lfsr  = 16'd17;
    slave_lfsr = 16'd17;
    errors = 0;
    checks = 0;
    acks = 0;
    for (int i = 0; i < `SQ_DEPTH; i++) exec_m[i] = 1'b0;
    @(posedge clock);
    while (reset) @(posedge clock);
    @(negedge clock);
    check_value("dispatch_ready", dispatch_ready, 1'b1);

    // Fill the queue, execute out of order, probe forwarding
    for (int i = 0; i < `SQ_DEPTH; i++) dispatch_one();
    @(negedge clock);
    check_value("dispatch_ready", dispatch_ready, 1'b0);
    for (int i = `SQ_DEPTH - 1; i >= 0; i--) begin
      execute_one(i);
      take_bits(stim_lfsr, 3, r);
      if (r[2:0] != 0) check_load(r[2:0]);
    end
    for (int i = 1; i < `SQ_DEPTH; i++) check_load(i);
    for (int i = 0; i < `SQ_DEPTH; i++) retire_one();
    while (acks == 0) @(posedge clock);
    @(negedge clock);
    check_value("dispatch_ready", dispatch_ready, 1'b1);
    wait_drained();

    // Mixed rounds with rollback of the youngest stores
    for (int k = 0; k < ROUNDS; k++) begin
      for (int i = 0; i < 4; i++) dispatch_one();
      for (int i = 1; i <= 4; i++) execute_one(tail_m - `SQ_INDEX_W'(i));
      wait_drained();
      check_load(tail_m);
      check_load(tail_m - 2'd2);
      rollback_to(commit_m + 2'd2);
      retire_one();
      retire_one();
    end
    wait_drained();
    repeat (4) @(posedge clock);
    checks++;
    assert (expected_writes.size() == 0) else begin
      errors++;
      $display("Retired stores never reached the Wishbone port");
    end

    errors += i_dut.i_asserts.failures;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+design
design/sq_pkg.sv
design/sq_pointers.sv
design/sq_drain_fsm.sv
design/sq_entries.sv
design/sq_forward.sv
design/store_queue.sv
bench/sq_clock_gen.sv
bench/sq_asserts.sv
bench/sq_tb.sv
